// ==== isa_pkg.sv ====
package isa_pkg;

    // register file geometry
    localparam int NUM_REGS = 32;
    localparam int REG_W    = $clog2(NUM_REGS);

    localparam int XLEN     = 32;   // data path width
    localparam int ADDR_W   = 32;

    typedef logic [REG_W-1:0]  reg_name_t;
    typedef logic [XLEN-1:0]   data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // x0 reads as zero and is never renamed
    localparam reg_name_t REG_ZERO = '0;

    // coarse operation class, enough to decide how an entry retires
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,   // no register write at commit
        op_branch = 2'd3    // link value is pc_next
    } op_class_e;

endpackage

// ==== rob_pkg.sv ====
package rob_pkg;

    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    typedef logic [TAG_W-1:0] rob_tag_t;
    typedef logic [TAG_W:0]   rob_count_t;  // 0 .. ROB_DEPTH

    // one instruction leaving decode
    typedef struct packed {
        isa_pkg::op_class_e op;
        isa_pkg::reg_name_t rd;
        isa_pkg::reg_name_t rs1;
        isa_pkg::reg_name_t rs2;
        logic               pred_taken;
        isa_pkg::addr_t     pc_next;    // fall-through address
    } issue_req_t;

    // source operand as seen by the reservation stations
    typedef struct packed {
        logic           ready;
        rob_tag_t       tag;    // producer, only meaningful when not ready
        isa_pkg::data_t value;
    } operand_t;

    // result bus from execution
    typedef struct packed {
        rob_tag_t       tag;
        isa_pkg::data_t data;
        logic           taken;
        isa_pkg::addr_t target;
    } wb_t;

    typedef struct packed {
        rob_tag_t           tag;
        isa_pkg::reg_name_t rd;
        isa_pkg::data_t     data;
        logic               is_store;
    } commit_t;

    typedef struct packed {
        isa_pkg::addr_t pc;
    } redirect_t;

endpackage

// ==== rob.sv ====
`timescale 1ns/1ps

module rob (
    input  logic                clk,
    input  logic                rst,

    input  logic                issue_valid,
    input  rob_pkg::issue_req_t issue,
    output logic                full,
    output rob_pkg::rob_tag_t   issue_tag,

    input  logic                wb_valid,
    input  rob_pkg::wb_t        wb,

    // two lookups by tag for operand forwarding
    input  rob_pkg::rob_tag_t   fwd_tag,
    output logic                fwd_done,
    output isa_pkg::data_t      fwd_data,
    input  rob_pkg::rob_tag_t   fwd2_tag,
    output logic                fwd2_done,
    output isa_pkg::data_t      fwd2_data,

    output logic                commit_valid,
    output rob_pkg::commit_t    commit,
    output logic                flush,
    output rob_pkg::redirect_t  redirect
);

    typedef struct packed {
        isa_pkg::op_class_e op;
        isa_pkg::reg_name_t rd;
        logic               pred_taken;
        logic               taken;
        isa_pkg::addr_t     target;
        isa_pkg::addr_t     pc_next;
        isa_pkg::data_t     data;
    } entry_t;

    entry_t                           entries [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::ROB_DEPTH-1:0]    done;

    rob_pkg::rob_tag_t   head;
    rob_pkg::rob_tag_t   tail;
    rob_pkg::rob_count_t count;

    entry_t              head_entry;
    logic                head_ready;
    logic                mispredict;
    logic                alloc;
    rob_pkg::rob_tag_t   wb_off;
    logic                wb_live;

    assign full      = (count == rob_pkg::rob_count_t'(rob_pkg::ROB_DEPTH));
    assign issue_tag = tail;
    assign alloc     = issue_valid && !full;   // issue while full is dropped

    assign head_entry = entries[head];
    assign head_ready = (count != '0) && done[head];
    assign mispredict = head_ready && (head_entry.op == isa_pkg::op_branch)
                        && (head_entry.taken != head_entry.pred_taken);

    // only tags inside [head, head+count) may complete
    assign wb_off  = wb.tag - head;
    assign wb_live = wb_valid && ({1'b0, wb_off} < count);

    // done stays set after retire, so a rename entry still pointing here
    // keeps forwarding until the commit clears it
    assign fwd_done  = done[fwd_tag];
    assign fwd_data  = entries[fwd_tag].data;
    assign fwd2_done = done[fwd2_tag];
    assign fwd2_data = entries[fwd2_tag].data;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= head_ready;
            flush        <= mispredict;

            if (mispredict) begin
                // everything younger than the branch is gone, incl. this cycle's issue
                head  <= '0;
                tail  <= '0;
                count <= '0;
                done  <= '0;
            end else begin
                if (head_ready)
                    head <= head + 1'b1;
                if (alloc) begin
                    tail       <= tail + 1'b1;
                    done[tail] <= 1'b0;
                end
                if (wb_live)
                    done[wb.tag] <= 1'b1;
                count <= count + rob_pkg::rob_count_t'(alloc)
                               - rob_pkg::rob_count_t'(head_ready);
            end
        end
    end

    // entry payload and commit/redirect payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            entries[tail] <= '{
                op:         issue.op,
                rd:         issue.rd,
                pred_taken: issue.pred_taken,
                taken:      1'b0,
                target:     '0,
                pc_next:    issue.pc_next,
                data:       '0
            };
        end

        if (wb_live) begin
            // branch result is the link address
            if (entries[wb.tag].op == isa_pkg::op_branch)
                entries[wb.tag].data <= entries[wb.tag].pc_next;
            else
                entries[wb.tag].data <= wb.data;
            entries[wb.tag].taken  <= wb.taken;
            entries[wb.tag].target <= wb.target;
        end

        if (head_ready) begin
            commit.tag      <= head;
            commit.rd       <= head_entry.rd;
            commit.data     <= head_entry.data;
            commit.is_store <= (head_entry.op == isa_pkg::op_store);
        end

        if (mispredict)
            redirect.pc <= head_entry.taken ? head_entry.target : head_entry.pc_next;
    end

endmodule

// ==== rename_table.sv ====
`timescale 1ns/1ps

module rename_table (
    input  logic               clk,
    input  logic               rst,

    input  logic               alloc_valid,
    input  isa_pkg::reg_name_t alloc_rd,
    input  rob_pkg::rob_tag_t  alloc_tag,

    input  logic               commit_valid,
    input  rob_pkg::commit_t   commit,
    input  logic               flush,

    input  isa_pkg::reg_name_t rs1,
    input  isa_pkg::reg_name_t rs2,
    output logic               rs1_busy,
    output logic               rs2_busy,
    output rob_pkg::rob_tag_t  rs1_tag,
    output rob_pkg::rob_tag_t  rs2_tag
);

    logic [isa_pkg::NUM_REGS-1:0] busy;
    rob_pkg::rob_tag_t            tags [isa_pkg::NUM_REGS];

    logic set_en;
    logic clr_en;

    assign set_en = alloc_valid && (alloc_rd != isa_pkg::REG_ZERO);

    // clear only if no younger producer took the register over
    assign clr_en = commit_valid && !commit.is_store
                    && (tags[commit.rd] == commit.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (flush)
                busy <= '0;
            else if (clr_en)
                busy[commit.rd] <= 1'b0;
            if (set_en)
                busy[alloc_rd] <= 1'b1;    // allocate wins
        end
    end

    always_ff @(posedge clk) begin
        if (set_en)
            tags[alloc_rd] <= alloc_tag;
    end

    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];
    assign rs1_tag  = tags[rs1];
    assign rs2_tag  = tags[rs2];

endmodule

// ==== arch_regfile.sv ====
`timescale 1ns/1ps

module arch_regfile (
    input  logic               clk,
    input  logic               rst,

    input  logic               wr_en,
    input  isa_pkg::reg_name_t wr_rd,
    input  isa_pkg::data_t     wr_data,

    input  isa_pkg::reg_name_t rs1,
    input  isa_pkg::reg_name_t rs2,
    output isa_pkg::data_t     rs1_data,
    output isa_pkg::data_t     rs2_data
);

    isa_pkg::data_t regs [isa_pkg::NUM_REGS];

    // write-through read, so the value committing this cycle is visible
    function automatic isa_pkg::data_t read_port(input isa_pkg::reg_name_t rs);
        isa_pkg::data_t val;
        if (rs == isa_pkg::REG_ZERO)
            val = '0;
        else if (wr_en && (wr_rd == rs))
            val = wr_data;
        else
            val = regs[rs];
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_rd != isa_pkg::REG_ZERO)) begin
            regs[wr_rd] <= wr_data;
        end
    end

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

endmodule

// ==== rob_core_top.sv ====
`timescale 1ns/1ps

module rob_core_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                issue_valid,
    input  rob_pkg::issue_req_t issue,
    input  logic                wb_valid,
    input  rob_pkg::wb_t        wb,

    output logic                full,
    output rob_pkg::rob_tag_t   issue_tag,
    output rob_pkg::operand_t   src1,
    output rob_pkg::operand_t   src2,
    output logic                commit_valid,
    output rob_pkg::commit_t    commit,
    output logic                flush,
    output rob_pkg::redirect_t  redirect
);

    logic              rename_alloc;
    logic              rf_wr_en;
    logic              rs1_busy;
    logic              rs2_busy;
    rob_pkg::rob_tag_t rs1_tag;
    rob_pkg::rob_tag_t rs2_tag;
    logic              fwd_done;
    logic              fwd2_done;
    isa_pkg::data_t    fwd_data;
    isa_pkg::data_t    fwd2_data;
    isa_pkg::data_t    rs1_data;
    isa_pkg::data_t    rs2_data;

    // x0, then committed value, then forwarded result, else wait on tag
    function automatic rob_pkg::operand_t resolve(
        input isa_pkg::reg_name_t rs,
        input logic               busy,
        input rob_pkg::rob_tag_t  tag,
        input logic               done,
        input isa_pkg::data_t     fwd,
        input isa_pkg::data_t     rf
    );
        rob_pkg::operand_t opnd;
        opnd = '0;
        if (rs == isa_pkg::REG_ZERO) begin
            opnd.ready = 1'b1;
        end else if (!busy) begin
            opnd.ready = 1'b1;
            opnd.value = rf;
        end else if (done) begin
            opnd.ready = 1'b1;
            opnd.value = fwd;
        end else begin
            opnd.tag = tag;
        end
        return opnd;
    endfunction

    assign rename_alloc = issue_valid && !full && (issue.op != isa_pkg::op_store);
    assign rf_wr_en     = commit_valid && !commit.is_store;

    // busy bits are stale during the flush cycle, the buffer is already empty
    assign src1 = resolve(issue.rs1, rs1_busy && !flush, rs1_tag, fwd_done, fwd_data, rs1_data);
    assign src2 = resolve(issue.rs2, rs2_busy && !flush, rs2_tag, fwd2_done, fwd2_data, rs2_data);

    rob i_rob (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .full         (full),
        .issue_tag    (issue_tag),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .fwd_tag      (rs1_tag),
        .fwd_done     (fwd_done),
        .fwd_data     (fwd_data),
        .fwd2_tag     (rs2_tag),
        .fwd2_done    (fwd2_done),
        .fwd2_data    (fwd2_data),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush),
        .redirect     (redirect)
    );

    rename_table i_rename_table (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (rename_alloc),
        .alloc_rd     (issue.rd),
        .alloc_tag    (issue_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush),
        .rs1          (issue.rs1),
        .rs2          (issue.rs2),
        .rs1_busy     (rs1_busy),
        .rs2_busy     (rs2_busy),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag)
    );

    arch_regfile i_arch_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (rf_wr_en),
        .wr_rd    (commit.rd),
        .wr_data  (commit.data),
        .rs1      (issue.rs1),
        .rs2      (issue.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// ==== tb_rob_core.sv ====
`timescale 1ns/1ps

module tb_rob_core;

    localparam int SEED         = 57425;
    localparam int RESET_CYCLES = 10;
    localparam int FILL_CYCLES  = 20;
    localparam int RAND_CYCLES  = 3000;
    localparam int DRAIN_CYCLES = 100;
    localparam int STIM_CYCLES  = RESET_CYCLES + FILL_CYCLES + RAND_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT      = 4 * STIM_CYCLES;

    // one live instruction as the model sees it
    typedef struct packed {
        rob_pkg::rob_tag_t  tag;
        isa_pkg::op_class_e op;
        isa_pkg::reg_name_t rd;
        logic               pred_taken;
        isa_pkg::addr_t     pc_next;
        logic               done;
        isa_pkg::data_t     data;
        logic               taken;
        isa_pkg::addr_t     target;
    } model_entry_t;

    logic                clk         = 1'b0;
    logic                rst         = 1'b1;
    logic                issue_valid = 1'b0;
    rob_pkg::issue_req_t issue       = '0;
    logic                wb_valid    = 1'b0;
    rob_pkg::wb_t        wb          = '0;

    logic                full;
    rob_pkg::rob_tag_t   issue_tag;
    rob_pkg::operand_t   src1;
    rob_pkg::operand_t   src2;
    logic                commit_valid;
    rob_pkg::commit_t    commit;
    logic                flush;
    rob_pkg::redirect_t  redirect;

    model_entry_t                 rob_q [$];     // oldest first
    isa_pkg::data_t               m_regs [isa_pkg::NUM_REGS];
    logic [isa_pkg::NUM_REGS-1:0] m_busy;
    rob_pkg::rob_tag_t            m_tag [isa_pkg::NUM_REGS];
    rob_pkg::rob_tag_t            m_tail;
    logic                         exp_commit_valid;
    rob_pkg::commit_t             exp_commit;
    logic                         exp_flush;
    rob_pkg::redirect_t           exp_redirect;
    int                           cycle_count = 0;
    int                           n_commits   = 0;
    int                           n_flushes   = 0;

    always #4 clk = ~clk;

    rob_core_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .full         (full),
        .issue_tag    (issue_tag),
        .src1         (src1),
        .src2         (src2),
        .commit_valid (commit_valid),
        .commit       (commit),
        .flush        (flush),
        .redirect     (redirect)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: the run went past %0d clock cycles", TIMEOUT);
            $display("Finished with errors");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic int find_entry(input rob_pkg::rob_tag_t tag);
        for (int i = 0; i < rob_q.size(); i++) begin
            if (rob_q[i].tag == tag)
                return i;
        end
        return -1;
    endfunction

    // x0, then committed value, then done producer, else pending tag
    function automatic rob_pkg::operand_t expected_operand(input isa_pkg::reg_name_t rs);
        rob_pkg::operand_t opnd;
        int                idx;
        opnd = '0;
        if (rs == isa_pkg::REG_ZERO) begin
            opnd.ready = 1'b1;
        end else if (!m_busy[rs]) begin
            opnd.ready = 1'b1;
            opnd.value = m_regs[rs];
        end else begin
            idx = find_entry(m_tag[rs]);
            if (idx >= 0 && rob_q[idx].done) begin
                opnd.ready = 1'b1;
                opnd.value = rob_q[idx].data;
            end else begin
                opnd.tag = m_tag[rs];
            end
        end
        return opnd;
    endfunction

    task automatic reset_model();
        rob_q.delete();
        m_busy           = '0;
        m_tail           = '0;
        exp_commit_valid = 1'b0;
        exp_flush        = 1'b0;
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            m_regs[i] = '0;
            m_tag[i]  = '0;
        end
    endtask

    // advance the model across one rising edge using the inputs held during the cycle
    task automatic model_edge();
        model_entry_t head;
        model_entry_t ent;
        logic         retire;
        logic         mispredict;
        logic         alloc;
        int           idx;
        head       = '0;
        retire     = (rob_q.size() > 0) && rob_q[0].done;
        mispredict = retire && (rob_q[0].op == isa_pkg::op_branch)
                     && (rob_q[0].taken != rob_q[0].pred_taken);
        alloc      = issue_valid && (rob_q.size() < rob_pkg::ROB_DEPTH) && !mispredict;
        exp_commit_valid = retire;
        exp_flush        = mispredict;
        if (retire) begin
            head = rob_q.pop_front();
            n_commits++;
            exp_commit.tag      = head.tag;
            exp_commit.rd       = head.rd;
            exp_commit.data     = head.data;
            exp_commit.is_store = (head.op == isa_pkg::op_store);
            if (head.op != isa_pkg::op_store && head.rd != isa_pkg::REG_ZERO) begin
                m_regs[head.rd] = head.data;
                if (m_tag[head.rd] == head.tag)
                    m_busy[head.rd] = 1'b0;
            end
        end
        if (mispredict) begin
            exp_redirect.pc = head.taken ? head.target : head.pc_next;
            rob_q.delete();   // younger work, this cycle's issue included
            m_busy = '0;
            m_tail = '0;
            n_flushes++;
        end else begin
            idx = wb_valid ? find_entry(wb.tag) : -1;
            if (idx >= 0) begin
                ent        = rob_q[idx];
                ent.done   = 1'b1;
                ent.data   = (ent.op == isa_pkg::op_branch) ? ent.pc_next : wb.data;
                ent.taken  = wb.taken;
                ent.target = wb.target;
                rob_q[idx] = ent;
            end
            if (alloc) begin
                ent            = '0;
                ent.tag        = m_tail;
                ent.op         = issue.op;
                ent.rd         = issue.rd;
                ent.pred_taken = issue.pred_taken;
                ent.pc_next    = issue.pc_next;
                rob_q.push_back(ent);
                if (issue.op != isa_pkg::op_store && issue.rd != isa_pkg::REG_ZERO) begin
                    m_busy[issue.rd] = 1'b1;
                    m_tag[issue.rd]  = m_tail;
                end
                m_tail = m_tail + 1'b1;
            end
        end
    endtask

    task automatic drive_inputs(input int issue_pct, input int wb_pct);
        rob_pkg::issue_req_t req;
        rob_pkg::wb_t        res;
        int                  pending [$];
        int                  pick;
        logic                fire;
        req = '0;
        case ($urandom % 8)
            0, 1, 2, 3: req.op = isa_pkg::op_alu;
            4, 5:       req.op = isa_pkg::op_load;
            6:          req.op = isa_pkg::op_store;
            default:    req.op = isa_pkg::op_branch;
        endcase
        req.rd         = isa_pkg::reg_name_t'($urandom % 8);  // few regs, many hazards
        req.rs1        = isa_pkg::reg_name_t'($urandom % 8);
        req.rs2        = isa_pkg::reg_name_t'($urandom % 8);
        req.pred_taken = 1'($urandom % 2);
        req.pc_next    = $urandom & 32'hffff_fffc;
        issue_valid <= (($urandom % 100) < issue_pct);
        issue       <= req;

        foreach (rob_q[i]) begin
            if (!rob_q[i].done)
                pending.push_back(i);
        end
        res  = '0;
        fire = (pending.size() > 0) && (($urandom % 100) < wb_pct);
        if (fire) begin
            pick       = pending[$urandom % pending.size()];
            res.tag    = rob_q[pick].tag;
            res.data   = $urandom;
            res.target = $urandom & 32'hffff_fffc;
            // one branch in four goes against its prediction
            res.taken  = (($urandom % 4) == 0) ? !rob_q[pick].pred_taken
                                                : rob_q[pick].pred_taken;
        end
        wb_valid <= fire;
        wb       <= res;
    endtask

    task automatic check_outputs();
        check("commit_valid", 64'(exp_commit_valid), 64'(commit_valid));
        if (exp_commit_valid)
            check("commit", 64'(exp_commit), 64'(commit));
        check("flush", 64'(exp_flush), 64'(flush));
        if (exp_flush)
            check("redirect", 64'(exp_redirect), 64'(redirect));
        check("full", 64'(rob_q.size() == rob_pkg::ROB_DEPTH), 64'(full));
        check("issue_tag", 64'(m_tail), 64'(issue_tag));
        if (issue_valid) begin
            check("src1", 64'(expected_operand(issue.rs1)), 64'(src1));
            check("src2", 64'(expected_operand(issue.rs2)), 64'(src2));
        end
    endtask

    task automatic run_cycle(input int issue_pct, input int wb_pct);
        @(posedge clk);
        model_edge();
        drive_inputs(issue_pct, wb_pct);
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        void'($urandom(SEED));
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs();   // idle after reset

        // no results yet, so the buffer fills and the last issues are ignored
        repeat (FILL_CYCLES) run_cycle(100, 0);
        check("full after fill", 64'(1), 64'(full));

        repeat (RAND_CYCLES) run_cycle(60, 70);

        run_cycle(0, 100);
        while (rob_q.size() != 0)
            run_cycle(0, 100);
        repeat (4) run_cycle(0, 0);

        $display("commits %0d, flushes %0d, cycles %0d", n_commits, n_flushes, cycle_count);
        if (n_flushes == 0 || n_commits == 0) begin
            $display("the run saw no commit or no mispredict flush");
            $display("Finished with errors");
            $fatal(1, "stimulus did not reach the recovery path");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== rob_core.f ====
isa_pkg.sv
rob_pkg.sv
rob.sv
rename_table.sv
arch_regfile.sv
rob_core_top.sv
tb_rob_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rob_core
FILELIST  ?= rob_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: PASS"; \
	else \
		echo "RESULT: FAIL, no end message in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
